// ==== hw/cpuPkg.sv ====
package cpuPkg;

  //////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////
  localparam int wordW = 32;
  localparam int regIdxW = 5;
  localparam int immW = 14;
  localparam int numRegs = 32;
  localparam int defaultMemDepth = 256;

  typedef logic [wordW-1:0] wordT;
  typedef logic [regIdxW-1:0] regIdxT;

  //////////////////////////////////////////////////
  // instruction word fields
  //////////////////////////////////////////////////
  localparam int funcHi = 31;
  localparam int funcLo = 27;
  localparam int rs1Hi = 26;
  localparam int rs1Lo = 22;
  localparam int rdHi = 21;
  localparam int rdLo = 17;
  localparam int rs2Hi = 16;
  localparam int rs2Lo = 12;
  localparam int saHi = 11;
  localparam int saLo = 7;
  // immediate overlaps rs2 and sa
  localparam int immHi = 16;
  localparam int immLo = 3;
  localparam int typeHi = 2;
  localparam int typeLo = 1;

  typedef enum logic [1:0] {
    typeR = 2'b00,
    typeJ = 2'b01,
    typeI = 2'b10,
    typeS = 2'b11
  } instrTypeE;

  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluSll = 3'd3,
    aluSrl = 3'd4
  } aluOpE;

  // all zero is a bubble
  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic useImm;
    aluOpE op;
  } ctrlT;

  // operand source selects from the hazard unit
  localparam logic [1:0] fwdNone = 2'd0;
  localparam logic [1:0] fwdEx = 2'd1;
  localparam logic [1:0] fwdMem = 2'd2;

endpackage

// ==== hw/pipeIf.sv ====
`timescale 1ns/1ps

// decode-to-execute register contents
interface exBus;
  cpuPkg::ctrlT ctrl;
  cpuPkg::wordT a;
  cpuPkg::wordT b;
  cpuPkg::wordT storeData;
  cpuPkg::regIdxT rd;

  modport decoder(output ctrl, a, b, storeData, rd);
  modport executor(input ctrl, a, b, storeData, rd);
endinterface

// results travelling back to decode for forwarding and stall
interface fwdBus;
  cpuPkg::regIdxT exRd;
  cpuPkg::ctrlT exCtrl;
  cpuPkg::wordT exResult;
  cpuPkg::regIdxT memRd;
  cpuPkg::ctrlT memCtrl;
  cpuPkg::wordT memResult;

  modport producerEx(output exRd, exCtrl, exResult);
  modport producerMem(output memRd, memCtrl, memResult);
  modport consumer(input exRd, exCtrl, exResult, memRd, memCtrl, memResult);
endinterface

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic Clk,
  input  logic rst,
  input  cpuPkg::regIdxT rdAddr1,
  input  cpuPkg::regIdxT rdAddr2,
  output cpuPkg::wordT rdData1,
  output cpuPkg::wordT rdData2,
  input  logic wrEn,
  input  cpuPkg::regIdxT wrAddr,
  input  cpuPkg::wordT wrData
);

  cpuPkg::wordT regs [cpuPkg::numRegs];
  logic wrLive;

  // r0 is never written, so it stays at its reset value
  assign wrLive = wrEn && (wrAddr != '0);

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 0; i < cpuPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rdData1 = (wrLive && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
  assign rdData2 = (wrLive && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
  input  cpuPkg::regIdxT rs1,
  input  cpuPkg::regIdxT rs2,
  input  logic uses2,
  fwdBus.consumer fwd,
  output logic [1:0] sel1,
  output logic [1:0] sel2,
  output logic loadStall
);

  // youngest producer wins; r0 is never forwarded
  function automatic logic [1:0] pickSrc(input cpuPkg::regIdxT idx,
                                         input cpuPkg::regIdxT exRd, input logic exWr,
                                         input cpuPkg::regIdxT memRd, input logic memWr);
    if (idx == '0) begin
      return cpuPkg::fwdNone;
    end else if (exWr && idx == exRd) begin
      return cpuPkg::fwdEx;
    end else if (memWr && idx == memRd) begin
      return cpuPkg::fwdMem;
    end
    return cpuPkg::fwdNone;
  endfunction

  assign sel1 = pickSrc(rs1, fwd.exRd, fwd.exCtrl.regWrite, fwd.memRd, fwd.memCtrl.regWrite);
  assign sel2 = uses2 ? pickSrc(rs2, fwd.exRd, fwd.exCtrl.regWrite, fwd.memRd,
                                fwd.memCtrl.regWrite)
                      : cpuPkg::fwdNone;

  // a load's data is not there until it sits in write-back
  assign loadStall = (sel1 == cpuPkg::fwdEx && fwd.exCtrl.memRead) ||
                     (sel1 == cpuPkg::fwdMem && fwd.memCtrl.memRead) ||
                     (sel2 == cpuPkg::fwdEx && fwd.exCtrl.memRead) ||
                     (sel2 == cpuPkg::fwdMem && fwd.memCtrl.memRead);

endmodule

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
  input  logic Clk,
  input  logic rst,
  input  cpuPkg::wordT instr,
  input  logic instrValid,
  output logic stall,
  exBus.decoder bus,
  fwdBus.consumer fwd,
  input  logic wbValid,
  input  cpuPkg::regIdxT wbRd,
  input  cpuPkg::wordT wbData
);

  logic decValid;
  cpuPkg::wordT decInstr;

  logic [4:0] func;
  cpuPkg::regIdxT rs1;
  cpuPkg::regIdxT rdF;
  cpuPkg::regIdxT rs2;
  logic [4:0] sa;
  logic [cpuPkg::immW-1:0] imm;
  cpuPkg::instrTypeE typ;

  cpuPkg::ctrlT decCtrl;
  logic zeroExt;
  logic uses2;
  logic isShift;
  cpuPkg::regIdxT readIdx1;
  cpuPkg::regIdxT src2Idx;
  cpuPkg::wordT rf1;
  cpuPkg::wordT rf2;
  logic [1:0] sel1;
  logic [1:0] sel2;
  cpuPkg::wordT opnd1;
  cpuPkg::wordT opnd2;
  cpuPkg::wordT opndB;
  cpuPkg::wordT immExt;
  cpuPkg::wordT saExt;

  function automatic cpuPkg::wordT fwdPick(input logic [1:0] sel, input cpuPkg::wordT rfVal,
                                           input cpuPkg::wordT exVal,
                                           input cpuPkg::wordT memVal);
    case (sel)
      cpuPkg::fwdEx: return exVal;
      cpuPkg::fwdMem: return memVal;
      default: return rfVal;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // decode register, held while stalled
  //////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (rst) begin
      decValid <= 1'b0;
    end else if (!stall) begin
      decValid <= instrValid;
    end
  end

  always_ff @(posedge Clk) begin
    if (!stall && instrValid) begin
      decInstr <= instr;
    end
  end

  assign func = decInstr[cpuPkg::funcHi:cpuPkg::funcLo];
  assign rs1 = decInstr[cpuPkg::rs1Hi:cpuPkg::rs1Lo];
  assign rdF = decInstr[cpuPkg::rdHi:cpuPkg::rdLo];
  assign rs2 = decInstr[cpuPkg::rs2Hi:cpuPkg::rs2Lo];
  assign sa = decInstr[cpuPkg::saHi:cpuPkg::saLo];
  assign imm = decInstr[cpuPkg::immHi:cpuPkg::immLo];
  assign typ = cpuPkg::instrTypeE'(decInstr[cpuPkg::typeHi:cpuPkg::typeLo]);

  // unknown type/func combinations stay all zero, i.e. a no-op
  always_comb begin
    decCtrl = '0;
    zeroExt = 1'b0;
    uses2 = 1'b0;
    if (decValid) begin
      case (typ)
        cpuPkg::typeR: begin
          decCtrl.regWrite = 1'b1;
          uses2 = 1'b1;
          case (func)
            5'd0: decCtrl.op = cpuPkg::aluAnd;
            5'd1: decCtrl.op = cpuPkg::aluAdd;
            5'd2: decCtrl.op = cpuPkg::aluSub;
            default: begin
              decCtrl.regWrite = 1'b0;
              uses2 = 1'b0;
            end
          endcase
        end
        cpuPkg::typeI: begin
          decCtrl.useImm = 1'b1;
          decCtrl.op = cpuPkg::aluAdd;
          case (func)
            5'd0: begin
              decCtrl.regWrite = 1'b1;
              decCtrl.op = cpuPkg::aluAnd;
              zeroExt = 1'b1;
            end
            5'd1: decCtrl.regWrite = 1'b1;
            5'd2: begin
              decCtrl.regWrite = 1'b1;
              decCtrl.memRead = 1'b1;
            end
            // store data comes from rd
            5'd3: begin
              decCtrl.memWrite = 1'b1;
              uses2 = 1'b1;
            end
            default: decCtrl.useImm = 1'b0;
          endcase
        end
        cpuPkg::typeS: begin
          case (func)
            5'd0: begin
              decCtrl.regWrite = 1'b1;
              decCtrl.op = cpuPkg::aluSll;
            end
            5'd1: begin
              decCtrl.regWrite = 1'b1;
              decCtrl.op = cpuPkg::aluSrl;
            end
            default: decCtrl = '0;
          endcase
        end
        default: decCtrl = '0;
      endcase
    end
  end

  // every kept instruction reads rs1; a no-op reads r0 and never stalls
  assign readIdx1 = (decCtrl.regWrite || decCtrl.memWrite) ? rs1 : '0;
  assign src2Idx = decCtrl.memWrite ? rdF : rs2;

  regFile regs (
    .Clk(Clk),
    .rst(rst),
    .rdAddr1(readIdx1),
    .rdAddr2(src2Idx),
    .rdData1(rf1),
    .rdData2(rf2),
    .wrEn(wbValid),
    .wrAddr(wbRd),
    .wrData(wbData)
  );

  hazardUnit hazard (
    .rs1(readIdx1),
    .rs2(src2Idx),
    .uses2(uses2),
    .fwd(fwd),
    .sel1(sel1),
    .sel2(sel2),
    .loadStall(stall)
  );

  //////////////////////////////////////////////////
  // operand selection
  //////////////////////////////////////////////////
  assign opnd1 = fwdPick(sel1, rf1, fwd.exResult, fwd.memResult);
  assign opnd2 = fwdPick(sel2, rf2, fwd.exResult, fwd.memResult);

  assign immExt = zeroExt ? {{(32 - cpuPkg::immW){1'b0}}, imm}
                          : {{(32 - cpuPkg::immW){imm[cpuPkg::immW-1]}}, imm};
  assign saExt = {27'd0, sa};
  assign isShift = (decCtrl.op == cpuPkg::aluSll) || (decCtrl.op == cpuPkg::aluSrl);
  assign opndB = decCtrl.useImm ? immExt : (isShift ? saExt : opnd2);

  // decode-to-execute register; a bubble goes in while stalled
  always_ff @(posedge Clk) begin
    if (rst) begin
      bus.ctrl <= '0;
      bus.rd <= '0;
    end else begin
      bus.ctrl <= stall ? '0 : decCtrl;
      bus.rd <= rdF;
    end
  end

  always_ff @(posedge Clk) begin
    bus.a <= opnd1;
    bus.b <= opndB;
    bus.storeData <= opnd2;
  end

endmodule

// ==== hw/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
  input  logic Clk,
  input  logic rst,
  exBus.executor bus,
  fwdBus.producerEx fwd,
  output cpuPkg::ctrlT memCtrl,
  output cpuPkg::wordT memResult,
  output cpuPkg::wordT memStoreData,
  output cpuPkg::regIdxT memRd
);

  cpuPkg::wordT aluOut;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    case (bus.ctrl.op)
      cpuPkg::aluAdd: aluOut = bus.a + bus.b;
      cpuPkg::aluSub: aluOut = bus.a - bus.b;
      cpuPkg::aluAnd: aluOut = bus.a & bus.b;
      // shift amount is the low 5 bits only
      cpuPkg::aluSll: aluOut = bus.a << bus.b[4:0];
      cpuPkg::aluSrl: aluOut = bus.a >> bus.b[4:0];
      default: aluOut = bus.a + bus.b;
    endcase
  end

  assign fwd.exRd = bus.rd;
  assign fwd.exCtrl = bus.ctrl;
  assign fwd.exResult = aluOut;

  // execute-to-memory register
  always_ff @(posedge Clk) begin
    if (rst) begin
      memCtrl <= '0;
      memRd <= '0;
    end else begin
      memCtrl <= bus.ctrl;
      memRd <= bus.rd;
    end
  end

  always_ff @(posedge Clk) begin
    memResult <= aluOut;
    memStoreData <= bus.storeData;
  end

endmodule

// ==== hw/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage #(
  parameter int memDepth = cpuPkg::defaultMemDepth
) (
  input  logic Clk,
  input  logic rst,
  input  cpuPkg::ctrlT memCtrl,
  input  cpuPkg::wordT memResult,
  input  cpuPkg::wordT memStoreData,
  input  cpuPkg::regIdxT memRd,
  fwdBus.producerMem fwd,
  output logic wbValid,
  output cpuPkg::regIdxT wbRd,
  output cpuPkg::wordT wbData
);

  localparam int addrW = $clog2(memDepth);

  cpuPkg::wordT ram [memDepth];
  logic [addrW-1:0] ramAddr;
  cpuPkg::wordT ramQ;
  cpuPkg::wordT wbAlu;
  logic wbLoad;

  assign fwd.memRd = memRd;
  assign fwd.memCtrl = memCtrl;
  assign fwd.memResult = memResult;

  // word addressed, wraps at memDepth
  assign ramAddr = addrW'(memResult % memDepth);

  //////////////////////////////////////////////////
  // data RAM
  //////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (memCtrl.memWrite) begin
      ram[ramAddr] <= memStoreData;
    end
    if (memCtrl.memRead) begin
      ramQ <= ram[ramAddr];
    end
  end

  // memory-to-write-back register
  always_ff @(posedge Clk) begin
    if (rst) begin
      wbValid <= 1'b0;
      wbRd <= '0;
      wbLoad <= 1'b0;
    end else begin
      wbValid <= memCtrl.regWrite && (memRd != '0);
      wbRd <= memRd;
      wbLoad <= memCtrl.memRead;
    end
  end

  always_ff @(posedge Clk) begin
    wbAlu <= memResult;
  end

  // write-back mux
  assign wbData = wbLoad ? ramQ : wbAlu;

endmodule

// ==== hw/pipeTop.sv ====
`timescale 1ns/1ps

module pipeTop #(
  parameter int memDepth = cpuPkg::defaultMemDepth
) (
  input  logic Clk,
  input  logic rst,
  input  cpuPkg::wordT instr,
  input  logic instrValid,
  output logic stall,
  output logic wbValid,
  output cpuPkg::regIdxT wbRd,
  output cpuPkg::wordT wbData
);

  cpuPkg::ctrlT memCtrl;
  cpuPkg::wordT memResult;
  cpuPkg::wordT memStoreData;
  cpuPkg::regIdxT memRd;

  exBus exIf ();
  fwdBus fwdIf ();

  decodeStage decode (
    .Clk(Clk),
    .rst(rst),
    .instr(instr),
    .instrValid(instrValid),
    .stall(stall),
    .bus(exIf.decoder),
    .fwd(fwdIf.consumer),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData)
  );

  executeStage execute (
    .Clk(Clk),
    .rst(rst),
    .bus(exIf.executor),
    .fwd(fwdIf.producerEx),
    .memCtrl(memCtrl),
    .memResult(memResult),
    .memStoreData(memStoreData),
    .memRd(memRd)
  );

  memoryStage #(
    .memDepth(memDepth)
  ) memory (
    .Clk(Clk),
    .rst(rst),
    .memCtrl(memCtrl),
    .memResult(memResult),
    .memStoreData(memStoreData),
    .memRd(memRd),
    .fwd(fwdIf.producerMem),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData)
  );

endmodule

// ==== dv/pipeTop_properties.sv ====
`timescale 1ns/1ps

module pipeTopProperties (
  input logic Clk,
  input logic rst,
  input logic stall,
  input logic wbValid,
  input logic [4:0] wbRd
);

  // pipeline comes out of reset empty
  resetQuiet: assert property (@(posedge Clk) rst |=> (!wbValid && !stall))
    else $error("wbValid or stall high in the cycle after reset");

  // r0 writes never reach write-back
  noR0Write: assert property (@(posedge Clk) disable iff (rst) wbValid |-> wbRd != 5'd0)
    else $error("write-back pulse targets r0");

  //////////////////////////////////////////////////
  // load-use stall lasts at most two cycles
  //////////////////////////////////////////////////
  stallBound: assert property (@(posedge Clk) disable iff (rst) stall ##1 stall |=> !stall)
    else $error("stall held for more than two cycles");

endmodule

bind pipeTop pipeTopProperties props (
  .Clk(Clk),
  .rst(rst),
  .stall(stall),
  .wbValid(wbValid),
  .wbRd(wbRd)
);

// ==== dv/pipeModel.svh ====
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// architectural state, no timing at all
logic [31:0] regModel [32];
logic [31:0] memModel [memDepth];
logic [4:0] expRd [$];
logic [31:0] expData [$];

//////////////////////////////////////////////////
// instruction encoders
//////////////////////////////////////////////////
function automatic logic [31:0] encR(input logic [4:0] f, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
  return {f, rs1, rd, rs2, 5'd0, 4'd0, 2'b00, 1'b0};
endfunction

function automatic logic [31:0] encI(input logic [4:0] f, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [13:0] imm);
  return {f, rs1, rd, imm, 2'b10, 1'b0};
endfunction

function automatic logic [31:0] encS(input logic [4:0] f, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] sa);
  return {f, rs1, rd, 5'd0, sa, 4'd0, 2'b11, 1'b0};
endfunction

task automatic modelReset();
  for (int i = 0; i < 32; i++) begin
    regModel[i] = '0;
  end
  expRd.delete();
  expData.delete();
endtask

// apply one accepted instruction and queue its expected write-back
task automatic modelApply(input logic [31:0] w);
  logic [4:0] f;
  logic [4:0] d;
  logic [31:0] a;
  logic [31:0] immS;
  logic [31:0] ea;
  logic [31:0] res;
  logic wr;
  f = w[31:27];
  d = w[21:17];
  a = regModel[w[26:22]];
  immS = {{18{w[16]}}, w[16:3]};
  ea = a + immS;
  res = '0;
  wr = 1'b0;
  case (w[2:1])
    2'b00: begin
      wr = (f <= 5'd2);
      case (f)
        5'd0: res = a & regModel[w[16:12]];
        5'd1: res = a + regModel[w[16:12]];
        5'd2: res = a - regModel[w[16:12]];
        default: res = '0;
      endcase
    end
    2'b10: begin
      wr = (f <= 5'd2);
      case (f)
        5'd0: res = a & {18'd0, w[16:3]};
        5'd1: res = ea;
        5'd2: res = memModel[ea % memDepth];
        5'd3: memModel[ea % memDepth] = regModel[d];
        default: res = '0;
      endcase
    end
    2'b11: begin
      wr = (f <= 5'd1);
      res = (f == 5'd0) ? (a << w[11:7]) : (a >> w[11:7]);
    end
    default: wr = 1'b0;
  endcase
  // r0 stays zero and never shows up on write-back
  if (wr && d != 5'd0) begin
    regModel[d] = res;
    expRd.push_back(d);
    expData.push_back(res);
  end
endtask

`endif

// ==== dv/pipeTb.sv ====
`timescale 1ns/1ps

module pipeTb;

  localparam int memDepth = 256;
  localparam int numInstr = 400;
  localparam int fillWords = 16;
  localparam int preambleLen = 2 * fillWords;
  localparam int progLen = preambleLen + numInstr;
  localparam int clkPeriod = 20;
  localparam int seed = 44628;
  localparam int watchdogNs = numInstr * 3 * clkPeriod + 2000;

  logic Clk;
  logic rst;
  logic [31:0] instr;
  logic instrValid;
  logic stall;
  logic wbValid;
  logic [4:0] wbRd;
  logic [31:0] wbData;

  logic [31:0] prog [progLen];
  logic stallSeen;
  int appliedCount;
  int checkedCount;
  int stallCycles;
  int errorCount;

  `include "pipeModel.svh"

  pipeTop #(
    .memDepth(memDepth)
  ) UUT (
    .Clk(Clk),
    .rst(rst),
    .instr(instr),
    .instrValid(instrValid),
    .stall(stall),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData)
  );

  initial begin
    Clk = 1'b0;
    forever #(clkPeriod / 2) Clk = ~Clk;
  end

  //////////////////////////////////////////////////
  // random program
  //////////////////////////////////////////////////
  // small register range keeps dependencies close together
  function automatic logic [31:0] randomInstr();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [31:0] w;
    rd = 5'($urandom % 8);
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    case ($urandom % 20)
      0, 1: return encR(5'd0, rd, rs1, rs2);
      2, 3: return encR(5'd1, rd, rs1, rs2);
      4, 5: return encR(5'd2, rd, rs1, rs2);
      6, 7: return encI(5'd0, rd, rs1, 14'($urandom));
      8, 9, 10: return encI(5'd1, rd, rs1, 14'($urandom));
      11, 12: return encI(5'd2, rd, 5'd0, 14'($urandom % 16));
      13, 14: return encI(5'd3, rd, 5'd0, 14'($urandom % 16));
      15, 16: return encS(5'd0, rd, rs1, 5'($urandom));
      17: return encS(5'd1, rd, rs1, 5'($urandom));
      default: begin
        // undefined type or func, must behave as a no-op
        if ($urandom % 2) begin
          w = $urandom;
          w[2:1] = 2'b01;
          return w;
        end
        return encR(5'(3 + $urandom % 29), rd, rs1, rs2);
      end
    endcase
  endfunction

  task automatic buildProgram();
    for (int i = 0; i < fillWords; i++) begin
      // each word gets a value of its own, through r1
      prog[2 * i] = encI(5'd1, 5'd1, 5'd0, 14'(i * 16'h0211 + 16'h0135));
      prog[2 * i + 1] = encI(5'd3, 5'd1, 5'd0, 14'(i));
    end
    for (int i = preambleLen; i < progLen; i++) begin
      prog[i] = randomInstr();
    end
  endtask

  //////////////////////////////////////////////////
  // expected stall
  //////////////////////////////////////////////////
  function automatic logic isLoad(input logic [31:0] w);
    return w[2:1] == 2'b10 && w[31:27] == 5'd2;
  endfunction

  // register an instruction writes, r0 if none
  function automatic logic [4:0] destOf(input logic [31:0] w);
    case (w[2:1])
      2'b00, 2'b10: return (w[31:27] <= 5'd2) ? w[21:17] : 5'd0;
      2'b11: return (w[31:27] <= 5'd1) ? w[21:17] : 5'd0;
      default: return 5'd0;
    endcase
  endfunction

  // r0 never counts as a source
  function automatic logic readsReg(input logic [31:0] w, input logic [4:0] r);
    logic [4:0] f;
    f = w[31:27];
    if (r == 5'd0) begin
      return 1'b0;
    end
    case (w[2:1])
      2'b00: return f <= 5'd2 && (w[26:22] == r || w[16:12] == r);
      2'b10: return (f <= 5'd3 && w[26:22] == r) || (f == 5'd3 && w[21:17] == r);
      2'b11: return f <= 5'd1 && w[26:22] == r;
      default: return 1'b0;
    endcase
  endfunction

  // a younger result in execute hides an older load in memory
  function automatic logic waitsOnLoad(input logic [31:0] dec, input logic [31:0] ex,
                                       input logic [31:0] mem);
    logic [4:0] exDst;
    logic [4:0] memDst;
    exDst = destOf(ex);
    memDst = destOf(mem);
    return (isLoad(ex) && readsReg(dec, exDst)) ||
           (isLoad(mem) && memDst != exDst && readsReg(dec, memDst));
  endfunction

  //////////////////////////////////////////////////
  // write-back checker
  //////////////////////////////////////////////////
  always @(negedge Clk) begin
    stallSeen = stall;
    if (!rst && stall) begin
      stallCycles++;
    end
  end

  always @(negedge Clk) begin : checkWriteBack
    logic [4:0] wantRd;
    logic [31:0] wantData;
    if (!rst && wbValid) begin
      if (expRd.size() == 0) begin
        $display("error at %0t: write-back to r%0d that the model did not expect", $time, wbRd);
        errorCount++;
      end else begin
        wantRd = expRd.pop_front();
        wantData = expData.pop_front();
        checkedCount++;
        if (wbRd !== wantRd || wbData !== wantData) begin
          $display("mismatch at %0t: expected r%0d = %h, got r%0d = %h",
                   $time, wantRd, wantData, wbRd, wbData);
          errorCount++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    int nextIdx;
    int drainCycles;
    logic holdInstr;
    logic stallWant;
    logic [31:0] decSlot;
    logic [31:0] exSlot;
    logic [31:0] memSlot;
    void'($urandom(seed));
    rst = 1'b1;
    instr = '0;
    instrValid = 1'b0;
    appliedCount = 0;
    checkedCount = 0;
    stallCycles = 0;
    errorCount = 0;
    nextIdx = 0;
    decSlot = '0;
    exSlot = '0;
    memSlot = '0;
    modelReset();
    buildProgram();
    repeat (10) @(posedge Clk);
    rst <= 1'b0;

    while (appliedCount < progLen) begin
      @(posedge Clk);
      // stall level over the cycle that just ended
      stallWant = waitsOnLoad(decSlot, exSlot, memSlot);
      if (stallSeen !== stallWant) begin
        $display("mismatch at %0t: expected stall %b, got %b", $time, stallWant, stallSeen);
        errorCount++;
      end
      // follow what moved down the pipe at this edge
      memSlot = exSlot;
      exSlot = stallSeen ? '0 : decSlot;
      if (instrValid && !stallSeen) begin
        decSlot = instr;
        modelApply(instr);
        appliedCount++;
      end else if (!stallSeen) begin
        decSlot = '0;
      end
      // a stalled instruction stays on the port
      holdInstr = instrValid && stallSeen;
      if (!holdInstr) begin
        if (nextIdx < progLen && ($urandom % 100) >= 20) begin
          instr <= prog[nextIdx];
          instrValid <= 1'b1;
          nextIdx++;
        end else begin
          instrValid <= 1'b0;
        end
      end
    end

    drainCycles = 0;
    while (expRd.size() != 0 && drainCycles < 20) begin
      @(posedge Clk);
      drainCycles++;
    end
    repeat (5) @(posedge Clk);
    if (expRd.size() != 0) begin
      $display("error: %0d expected write-backs never came out", expRd.size());
      errorCount++;
    end

    $display("checked %0d write-backs, %0d stall cycles, %0d errors",
             checkedCount, stallCycles, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdogNs);
    $display("error: the run timed out after %0d ns with %0d of %0d instructions accepted",
             watchdogNs, appliedCount, progLen);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+dv
hw/cpuPkg.sv
hw/pipeIf.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/pipeTop.sv
dv/pipeTop_properties.sv
dv/pipeTb.sv
